/* source/aes_pkg.sv */
package aes_pkg;

// ====================
// Data types
// ====================

// One 128-bit block, byte 0 in the top bits
typedef logic [127:0] block_t;

// One column of the state or one key word
typedef logic [31:0] word_t;

// One state byte
typedef logic [7:0] byte_t;

// Round counter value, 0 to 10
typedef logic [3:0] round_t;

// Final AES-128 round
localparam round_t LAST_ROUND = 4'd10;

// ====================
// Control encodings
// ====================

// Round FSM states
typedef enum logic [3:0] {
	IDLE       = 4'd0,
	INIT_COL0  = 4'd1,
	INIT_COL1  = 4'd2,
	INIT_COL2  = 4'd3,
	INIT_COL3  = 4'd4,
	KEY_STEP   = 4'd5,
	ROUND_COL0 = 4'd6,
	ROUND_COL1 = 4'd7,
	ROUND_COL2 = 4'd8,
	ROUND_COL3 = 4'd9,
	READY      = 4'd10
} ctrl_state_t;

// State datapath operations
// FINAL is the round without MixColumns
typedef enum logic [2:0] {
	HOLD    = 3'd0,
	LOAD    = 3'd1,
	ADD_KEY = 3'd2,
	SHIFT   = 3'd3,
	ROUND   = 3'd4,
	FINAL   = 3'd5
} col_sel_t;

// Multiply by x in GF(2^8), reduced by x^8 + x^4 + x^3 + x + 1
function automatic byte_t xtime(input byte_t b);
	xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

endpackage

/* source/aes_sbox.sv */
`timescale 1ns/100ps

module aes_sbox import aes_pkg::*;
(
	input  word_t src_word,
	output word_t sub_word
);

// Shift-and-add multiply in GF(2^8)
function automatic byte_t gf_mul(input byte_t a, input byte_t b);
	byte_t acc;
	byte_t sh;
	acc = 8'h00;
	sh  = a;
	for (int i = 0; i < 8; i++)
	begin
		if (b[i])
			acc = acc ^ sh;
		sh = xtime(sh);
	end
	gf_mul = acc;
endfunction

// Inverse as a^254, zero maps to zero
function automatic byte_t gf_inv(input byte_t a);
	byte_t a2;
	byte_t a3;
	byte_t a12;
	byte_t a15;
	byte_t a240;
	a2   = gf_mul(a, a);
	a3   = gf_mul(a2, a);
	// a^12 from two squarings of a^3
	a12  = gf_mul(gf_mul(a3, a3), gf_mul(a3, a3));
	a15  = gf_mul(a12, a3);
	// Four squarings take a^15 to a^240
	a240 = gf_mul(a15, a15);
	a240 = gf_mul(a240, a240);
	a240 = gf_mul(a240, a240);
	a240 = gf_mul(a240, a240);
	gf_inv = gf_mul(gf_mul(a240, a12), a2);
endfunction

// Affine map over GF(2), constant 0x63
function automatic byte_t sub_byte(input byte_t a);
	byte_t b;
	b = gf_inv(a);
	sub_byte = b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
		^ {b[3:0], b[7:4]} ^ 8'h63;
endfunction

// Four bytes in parallel
assign sub_word = {sub_byte(src_word[31:24]), sub_byte(src_word[23:16]),
	sub_byte(src_word[15:8]), sub_byte(src_word[7:0])};

endmodule

/* source/aes_control_unit.sv */
`timescale 1ns/100ps

module aes_control_unit import aes_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  logic       abort,
	input  logic       mode_ctr,
	output col_sel_t   col_sel,
	output logic [1:0] col_idx,
	output logic       key_load,
	output logic       key_step,
	output logic       key_col_en,
	output logic       sbox_g,
	output logic       load_ctr,
	output round_t     round,
	output logic       finish,
	output logic       busy
);

ctrl_state_t state;
ctrl_state_t next_state;
round_t      rd_count;
logic        loaded;
logic        launch;
logic        last_round;

// Start accepted only in IDLE and not twice in a row
assign launch     = (state == IDLE) && start && !loaded;
assign last_round = (rd_count == LAST_ROUND);

// ====================
// State register
// ====================
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		state <= IDLE;
	else if (abort)
		state <= IDLE;
	else
		state <= next_state;
end

// Marks the load cycle, round 0 begins on the next edge
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		loaded <= 1'b0;
	else if (abort)
		loaded <= 1'b0;
	else
		loaded <= launch;
end

// Next state logic
always_comb
begin
	next_state = state;
	case (state)
		IDLE:       next_state = loaded ? INIT_COL0 : IDLE;
		INIT_COL0:  next_state = INIT_COL1;
		INIT_COL1:  next_state = INIT_COL2;
		INIT_COL2:  next_state = INIT_COL3;
		INIT_COL3:  next_state = KEY_STEP;
		KEY_STEP:   next_state = ROUND_COL0;
		ROUND_COL0: next_state = ROUND_COL1;
		ROUND_COL1: next_state = ROUND_COL2;
		ROUND_COL2: next_state = ROUND_COL3;
		// Loop back for the next round or finish
		ROUND_COL3: next_state = last_round ? READY : KEY_STEP;
		READY:      next_state = IDLE;
		default:    next_state = IDLE;
	endcase
end

// ====================
// Output decode
// ====================
always_comb
begin
	col_sel    = HOLD;
	key_load   = 1'b0;
	key_step   = 1'b0;
	key_col_en = 1'b0;
	sbox_g     = 1'b0;
	case (state)
		IDLE:
		begin
			// Key and input block captured on the start edge
			if (launch)
			begin
				col_sel  = LOAD;
				key_load = 1'b1;
			end
		end
		INIT_COL0, INIT_COL1, INIT_COL2, INIT_COL3:
			col_sel = ADD_KEY;
		KEY_STEP:
		begin
			// S-box lent to the g-function, state rows rotated meanwhile
			col_sel  = SHIFT;
			key_step = 1'b1;
			sbox_g   = 1'b1;
		end
		ROUND_COL0, ROUND_COL1, ROUND_COL2, ROUND_COL3:
		begin
			col_sel    = last_round ? FINAL : ROUND;
			key_col_en = 1'b1;
		end
		default:
			col_sel = HOLD;
	endcase
end

// Column pointer follows the state
always_comb
begin
	case (state)
		INIT_COL1, ROUND_COL1: col_idx = 2'd1;
		INIT_COL2, ROUND_COL2: col_idx = 2'd2;
		INIT_COL3, ROUND_COL3: col_idx = 2'd3;
		default:               col_idx = 2'd0;
	endcase
end

// Round counter, Rcon index during KEY_STEP
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		rd_count <= 4'd0;
	else if (state == IDLE)
		rd_count <= 4'd0;
	else if (state == KEY_STEP)
		rd_count <= rd_count + 1'b1;
end

assign round    = rd_count;
assign load_ctr = launch && mode_ctr;
// No result when the last cycle is aborted
assign finish   = (state == READY) && !abort;
assign busy     = (state != IDLE);

endmodule

/* source/aes_key_schedule.sv */
`timescale 1ns/100ps

module aes_key_schedule import aes_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  block_t     key,
	input  logic       key_load,
	input  logic       key_step,
	input  logic       key_col_en,
	input  logic [1:0] col_idx,
	input  round_t     round,
	input  word_t      sbox_word,
	output word_t      g_word,
	output word_t      round_key_word
);

// Current round key, w[0] from the top bits of the key
word_t [0:3] w;
word_t       prev_word;
byte_t       rcon;

// Round constant for the key step of round+1
always_comb
begin
	case (round)
		4'd0:    rcon = 8'h01;
		4'd1:    rcon = 8'h02;
		4'd2:    rcon = 8'h04;
		4'd3:    rcon = 8'h08;
		4'd4:    rcon = 8'h10;
		4'd5:    rcon = 8'h20;
		4'd6:    rcon = 8'h40;
		4'd7:    rcon = 8'h80;
		4'd8:    rcon = 8'h1b;
		4'd9:    rcon = 8'h36;
		default: rcon = 8'h00;
	endcase
end

// RotWord of w3, substituted by the shared S-box
assign g_word = {w[3][23:0], w[3][31:24]};

// Word to the left, already updated this round
assign prev_word = w[col_idx - 2'd1];

// Expanded word in round columns 1 to 3
// Round 0 and column 0 pass the stored word
assign round_key_word = (key_col_en && (col_idx != 2'd0)) ?
	(w[col_idx] ^ prev_word) : w[col_idx];

// ====================
// Key word registers
// ====================
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		w <= '0;
	else if (key_load)
		w <= key;
	else if (key_step)
		// First word of the next round key
		w[0] <= w[0] ^ sbox_word ^ {rcon, 24'h000000};
	else if (key_col_en)
		// One word per column cycle
		w[col_idx] <= round_key_word;
end

endmodule

/* source/aes_state_datapath.sv */
`timescale 1ns/100ps

module aes_state_datapath import aes_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  col_sel_t   col_sel,
	input  logic [1:0] col_idx,
	input  block_t     in_block,
	input  word_t      sbox_word,
	input  word_t      round_key_word,
	output word_t      col_word,
	output block_t     cipher_block
);

// Column registers, column 0 in the top bits
word_t [0:3] col;
word_t [0:3] shifted;
word_t       mixed;

// MixColumns on one column
function automatic word_t mix_column(input word_t w);
	byte_t a0;
	byte_t a1;
	byte_t a2;
	byte_t a3;
	a0 = w[31:24];
	a1 = w[23:16];
	a2 = w[15:8];
	a3 = w[7:0];
	// Rows of the circulant 2 3 1 1
	mix_column = {
		xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
		a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
		a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
		xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
	};
endfunction

// ====================
// ShiftRows
// ====================

// Row r moves left by r columns
always_comb
begin
	for (int c = 0; c < 4; c++)
	begin
		for (int r = 0; r < 4; r++)
			shifted[c][31 - 8 * r -: 8] = col[(c + r) % 4][31 - 8 * r -: 8];
	end
end

// SubBytes done by the S-box on col_word
assign mixed = mix_column(sbox_word);

// ====================
// Column update
// ====================
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		col <= '0;
	else
	begin
		case (col_sel)
			LOAD:
				col <= in_block;
			// Round 0 key addition
			ADD_KEY:
				col[col_idx] <= col[col_idx] ^ round_key_word;
			SHIFT:
				col <= shifted;
			ROUND:
				col[col_idx] <= mixed ^ round_key_word;
			// Round 10 skips MixColumns
			FINAL:
				col[col_idx] <= sbox_word ^ round_key_word;
			default:
				col <= col;
		endcase
	end
end

// Selected column to the S-box
assign col_word     = col[col_idx];
assign cipher_block = col;

endmodule

/* source/aes_output_stage.sv */
`timescale 1ns/100ps

module aes_output_stage import aes_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   mode_ctr,
	input  block_t iv,
	input  logic   iv_load,
	input  logic   finish,
	input  logic   busy,
	input  block_t data_in,
	input  block_t cipher_block,
	output block_t ctr_block,
	output block_t data_out,
	output logic   done
);

block_t result;

// CTR applies the keystream to the host data
assign result = mode_ctr ? (cipher_block ^ data_in) : cipher_block;

// ====================
// Result and done
// ====================
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
	begin
		data_out <= '0;
		done     <= 1'b0;
	end
	else
	begin
		// One-cycle pulse after READY
		done <= finish;
		if (finish)
			data_out <= result;
	end
end

// Counter block
// IV writes only while idle, low word steps after each CTR block
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		ctr_block <= '0;
	else if (iv_load && !busy)
		ctr_block <= iv;
	else if (finish && mode_ctr)
		ctr_block[31:0] <= ctr_block[31:0] + 32'd1;
end

endmodule

/* source/aes_core_top.sv */
`timescale 1ns/100ps

module aes_core_top import aes_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   start,
	input  logic   abort,
	input  logic   mode_ctr,
	input  block_t key,
	input  block_t data_in,
	input  block_t iv,
	input  logic   iv_load,
	output block_t data_out,
	output logic   done,
	output logic   busy
);

// Control selects
col_sel_t   col_sel;
logic [1:0] col_idx;
logic       key_load;
logic       key_step;
logic       key_col_en;
logic       sbox_g;
logic       load_ctr;
round_t     round;
logic       finish;

// Datapath words
word_t  sbox_in;
word_t  sbox_word;
word_t  g_word;
word_t  col_word;
word_t  round_key_word;
block_t in_block;
block_t cipher_block;
block_t ctr_block;

// ====================
// Input muxes
// ====================

// Key word in KEY_STEP, state column otherwise
assign sbox_in  = sbox_g ? g_word : col_word;
// CTR ciphers the counter, ECB the host data
assign in_block = load_ctr ? ctr_block : data_in;

aes_control_unit u_control
(
	.clk        (clk),
	.rst_n      (rst_n),
	.start      (start),
	.abort      (abort),
	.mode_ctr   (mode_ctr),
	.col_sel    (col_sel),
	.col_idx    (col_idx),
	.key_load   (key_load),
	.key_step   (key_step),
	.key_col_en (key_col_en),
	.sbox_g     (sbox_g),
	.load_ctr   (load_ctr),
	.round      (round),
	.finish     (finish),
	.busy       (busy)
);

aes_sbox u_sbox
(
	.src_word (sbox_in),
	.sub_word (sbox_word)
);

aes_key_schedule u_key
(
	.clk            (clk),
	.rst_n          (rst_n),
	.key            (key),
	.key_load       (key_load),
	.key_step       (key_step),
	.key_col_en     (key_col_en),
	.col_idx        (col_idx),
	.round          (round),
	.sbox_word      (sbox_word),
	.g_word         (g_word),
	.round_key_word (round_key_word)
);

aes_state_datapath u_state
(
	.clk            (clk),
	.rst_n          (rst_n),
	.col_sel        (col_sel),
	.col_idx        (col_idx),
	.in_block       (in_block),
	.sbox_word      (sbox_word),
	.round_key_word (round_key_word),
	.col_word       (col_word),
	.cipher_block   (cipher_block)
);

aes_output_stage u_output
(
	.clk          (clk),
	.rst_n        (rst_n),
	.mode_ctr     (mode_ctr),
	.iv           (iv),
	.iv_load      (iv_load),
	.finish       (finish),
	.busy         (busy),
	.data_in      (data_in),
	.cipher_block (cipher_block),
	.ctr_block    (ctr_block),
	.data_out     (data_out),
	.done         (done)
);

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen
(
	output logic clk,
	output logic rst_n
);

localparam int PERIOD = 100;

// Free-running clock, starts low
initial
begin
	clk = 1'b0;
	forever
		#(PERIOD / 2) clk = ~clk;
end

// Reset low over the first three cycles
initial
begin
	rst_n = 1'b0;
	repeat (3) @(posedge clk);
	// Released on a falling edge, away from the sampling edge
	@(negedge clk);
	rst_n = 1'b1;
end

endmodule

/* testbench/tb_aes_core.sv */
`timescale 1ns/100ps

module tb_aes_core import aes_pkg::*;
();

localparam int CYCLE_NS  = 100;
localparam int LATENCY   = 56;
localparam int OP_ECB    = 0;
localparam int OP_CTR    = 1;
localparam int OP_LOADIV = 2;
localparam int OP_ABORT  = 3;

// DUT signals
logic   clk;
logic   rst_n;
logic   start;
logic   abort;
logic   mode_ctr;
logic   iv_load;
block_t key;
block_t data_in;
block_t iv;
block_t data_out;
logic   done;
logic   busy;

// Vector table from the data file
int     op_q[$];
block_t key_q[$];
block_t data_q[$];
block_t iv_q[$];
block_t exp_q[$];

int     num_vectors = 0;
int     errors = 0;
int     tests_run = 0;
int     tests_failed = 0;
integer seed;
logic   load_ok;

tb_clock_gen clk_gen0
(
	.clk   (clk),
	.rst_n (rst_n)
);

aes_core_top dut0
(
	.clk      (clk),
	.rst_n    (rst_n),
	.start    (start),
	.abort    (abort),
	.mode_ctr (mode_ctr),
	.key      (key),
	.data_in  (data_in),
	.iv       (iv),
	.iv_load  (iv_load),
	.data_out (data_out),
	.done     (done),
	.busy     (busy)
);

// ====================
// Compare tasks
// ====================
task automatic compare_block(input string what, input block_t got, input block_t exp);
	if (got !== exp)
	begin
		$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		errors++;
	end
endtask

task automatic compare_flag(input string what, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		errors++;
	end
endtask

// Operation text to code, -1 if unknown
function automatic int op_code(input logic [63:0] text);
	case (text)
		"ECB":    op_code = OP_ECB;
		"CTR":    op_code = OP_CTR;
		"LOADIV": op_code = OP_LOADIV;
		"ABORT":  op_code = OP_ABORT;
		default:  op_code = -1;
	endcase
endfunction

function automatic string op_label(input int op);
	case (op)
		OP_ECB:    op_label = "ECB";
		OP_CTR:    op_label = "CTR";
		OP_LOADIV: op_label = "LOADIV";
		default:   op_label = "ABORT";
	endcase
endfunction

// ====================
// Vector file
// ====================
task automatic load_vectors();
	int          fd;
	int          n;
	int          op;
	int          line_no;
	string       line;
	logic [63:0] op_text;
	block_t      k_val;
	block_t      d_val;
	block_t      v_val;
	block_t      x_val;
	load_ok = 1'b0;
	line_no = 0;
	fd = $fopen("testbench/aes_vectors.txt", "r");
	if (fd == 0)
	begin
		$display("Could not open testbench/aes_vectors.txt");
		errors++;
	end
	else
	begin
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			line_no++;
			// Blank and comment lines skipped
			if (n > 0 && line.len() > 1 && line[0] != "#")
			begin
				n = $sscanf(line, "%s %h %h %h %h", op_text, k_val, d_val, v_val, x_val);
				op = op_code(op_text);
				if (n != 5 || op < 0)
				begin
					$display("Vector file line %0d could not be read", line_no);
					errors++;
				end
				else
				begin
					op_q.push_back(op);
					key_q.push_back(k_val);
					data_q.push_back(d_val);
					iv_q.push_back(v_val);
					exp_q.push_back(x_val);
				end
			end
		end
		$fclose(fd);
		num_vectors = op_q.size();
		load_ok = (num_vectors > 0);
		if (!load_ok)
		begin
			$display("No test vectors found in testbench/aes_vectors.txt");
			errors++;
		end
	end
endtask

// ====================
// Test sequences
// ====================

// One block, fixed latency, second start while busy
task automatic run_block(input logic ctr, input block_t k_val, input block_t d_val,
	input block_t x_val);
	int extra;
	extra = 5 + ({$random(seed)} % 40);
	@(posedge clk);
	mode_ctr <= ctr;
	key      <= k_val;
	data_in  <= d_val;
	start    <= 1'b1;
	// Start sampled on this edge
	@(posedge clk);
	start <= 1'b0;
	for (int e = 1; e <= LATENCY; e++)
	begin
		@(posedge clk);
		start <= (e == extra);
		@(negedge clk);
		if (e < LATENCY)
		begin
			compare_flag("done during run", done, 1'b0);
			compare_flag("busy during run", busy, 1'b1);
		end
		else if (done !== 1'b1)
		begin
			$display("No done pulse %0d cycles after start, at %0t", LATENCY, $time);
			errors++;
		end
		else
		begin
			compare_block("data_out", data_out, x_val);
			compare_flag("busy at done", busy, 1'b0);
		end
	end
	// Ignored start must not launch a second run
	repeat (3)
	begin
		@(negedge clk);
		compare_flag("done after run", done, 1'b0);
		compare_flag("busy after run", busy, 1'b0);
	end
endtask

// Run cut short, old result kept
task automatic run_abort(input block_t k_val, input block_t d_val, input block_t prev_out);
	int abort_at;
	abort_at = 10 + ({$random(seed)} % 30);
	@(posedge clk);
	mode_ctr <= 1'b0;
	key      <= k_val;
	data_in  <= d_val;
	start    <= 1'b1;
	@(posedge clk);
	start <= 1'b0;
	repeat (abort_at) @(posedge clk);
	@(negedge clk);
	compare_flag("busy before abort", busy, 1'b1);
	@(posedge clk);
	abort <= 1'b1;
	@(posedge clk);
	abort <= 1'b0;
	@(negedge clk);
	compare_flag("busy after abort", busy, 1'b0);
	repeat (60)
	begin
		@(negedge clk);
		compare_flag("done after abort", done, 1'b0);
	end
	compare_block("data_out after abort", data_out, prev_out);
endtask

// Counter write while idle
task automatic load_counter(input block_t v_val);
	@(posedge clk);
	iv      <= v_val;
	iv_load <= 1'b1;
	@(posedge clk);
	iv_load <= 1'b0;
	@(negedge clk);
	compare_flag("busy after iv_load", busy, 1'b0);
endtask

task automatic report_test(input string label, input int err_mark);
	tests_run++;
	if (errors != err_mark)
	begin
		tests_failed++;
		$display("Test %0d %s: failed at %0t", tests_run, label, $time);
	end
	else
		$display("Test %0d %s: ok at %0t", tests_run, label, $time);
endtask

// ====================
// Main sequence
// ====================
initial
begin
	int err_mark;
	int gap;
	$timeformat(-9, 0, " ns", 0);
	seed     = 32'h55e0_620f;
	start    = 1'b0;
	abort    = 1'b0;
	mode_ctr = 1'b0;
	iv_load  = 1'b0;
	key      = '0;
	data_in  = '0;
	iv       = '0;
	load_vectors();
	wait (rst_n === 1'b1);
	@(negedge clk);
	// Reset values
	err_mark = errors;
	compare_flag("done after reset", done, 1'b0);
	compare_flag("busy after reset", busy, 1'b0);
	compare_block("data_out after reset", data_out, '0);
	report_test("reset", err_mark);
	if (load_ok)
	begin
		for (int i = 0; i < num_vectors; i++)
		begin
			// Random idle gap between tests
			gap = 1 + ({$random(seed)} % 6);
			repeat (gap) @(posedge clk);
			err_mark = errors;
			case (op_q[i])
				OP_ECB:    run_block(1'b0, key_q[i], data_q[i], exp_q[i]);
				OP_CTR:    run_block(1'b1, key_q[i], data_q[i], exp_q[i]);
				OP_LOADIV: load_counter(iv_q[i]);
				default:   run_abort(key_q[i], data_q[i], exp_q[i]);
			endcase
			report_test(op_label(op_q[i]), err_mark);
		end
	end
	$display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
		tests_run, tests_run - tests_failed, tests_failed, errors);
	if (errors == 0 && tests_failed == 0)
		$display("All tests passed");
	else
		$display("Some tests failed");
	$finish;
end

// Watchdog, 100 cycles per vector
initial
begin
	wait (num_vectors > 0);
	#(num_vectors * 100 * CYCLE_NS);
	$display("Watchdog expired, the run did not finish in time");
	$display("Some tests failed");
	$finish;
end

endmodule

/* testbench/aes_vectors.txt */
# Columns: operation, key, data, iv, expected data_out, all hex
# ABORT expects data_out to keep the result of the run before it
# FIPS-197 appendix C.1 and appendix B
ECB 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 0 69c4e0d86a7b0430d8cdb78070b4c55a
ECB 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 0 3925841d02dc09fbdc118597196a0b32
# SP 800-38A F.5.1, initial counter block loaded first
LOADIV 0 0 f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff 0
CTR 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 0 874d6191b620e3261bef6864990db6ce
CTR 2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 0 9806f66b7970fdff8617187bb9fffdff
CTR 2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 0 5ae4df3edbd5d35e5b4f09020db03eab
# Aborted run, then the same block run to the end
ABORT 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 0 5ae4df3edbd5d35e5b4f09020db03eab
ECB 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 0 69c4e0d86a7b0430d8cdb78070b4c55a
ECB 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 0 3925841d02dc09fbdc118597196a0b32

/* tb.f */
source/aes_pkg.sv
source/aes_sbox.sv
source/aes_control_unit.sv
source/aes_key_schedule.sv
source/aes_state_datapath.sv
source/aes_output_stage.sv
source/aes_core_top.sv
testbench/tb_clock_gen.sv
testbench/tb_aes_core.sv

/* Makefile */
# Verilator simulation of the AES core testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, result taken from $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_aes_core -o tb_sim
	./obj_dir/tb_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
